//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Mdir obj_dir
TOP       = tb_int_pipeline
FILELIST  = sim.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- hw/core_pkg.sv
package core_pkg;

    //////////////////////////////
    // Widths and vector types
    //////////////////////////////

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  byte_en_t;
    typedef logic [3:0]  alu_op_t;
    typedef logic [2:0]  mem_size_t;

    // ALU operations
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_AND    = 4'd2;
    localparam alu_op_t ALU_OR     = 4'd3;
    localparam alu_op_t ALU_XOR    = 4'd4;
    localparam alu_op_t ALU_SLL    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_SLT    = 4'd8;
    localparam alu_op_t ALU_SLTU   = 4'd9;
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // Memory access size, same coding as funct3
    localparam mem_size_t SIZE_B  = 3'd0;
    localparam mem_size_t SIZE_H  = 3'd1;
    localparam mem_size_t SIZE_W  = 3'd2;
    localparam mem_size_t SIZE_BU = 3'd4;
    localparam mem_size_t SIZE_HU = 3'd5;

    // Arithmetic funct3
    localparam logic [2:0] F3_ADD  = 3'd0;
    localparam logic [2:0] F3_SLL  = 3'd1;
    localparam logic [2:0] F3_SLT  = 3'd2;
    localparam logic [2:0] F3_SLTU = 3'd3;
    localparam logic [2:0] F3_XOR  = 3'd4;
    localparam logic [2:0] F3_SR   = 3'd5;
    localparam logic [2:0] F3_OR   = 3'd6;
    localparam logic [2:0] F3_AND  = 3'd7;

    // Major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // addi x0, x0, 0
    localparam word_t NOP_WORD = 32'h0000_0013;

endpackage

//--- hw/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                advance,
    input  logic                ins_valid,
    input  core_pkg::word_t     ins,
    output logic                take,
    input  core_pkg::reg_addr_t ex_rd,
    input  core_pkg::word_t     ex_result,
    input  logic                ex_is_load,
    input  logic                wb_en,
    input  core_pkg::reg_addr_t wb_rd,
    input  core_pkg::word_t     wb_data,
    output core_pkg::word_t     op_a,
    output core_pkg::word_t     op_b,
    output core_pkg::word_t     store_val,
    output core_pkg::alu_op_t   alu_op,
    output core_pkg::mem_size_t mem_size,
    output logic                is_load,
    output logic                is_store,
    output core_pkg::reg_addr_t rd
);
    import core_pkg::*;

    word_t     instr_q;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rf_a;
    word_t     rf_b;
    word_t     fwd_a;
    word_t     fwd_b;
    word_t     imm;
    logic      b_is_imm;
    logic      use_rs1;
    logic      use_rs2;
    logic      load_d;
    logic      store_d;
    alu_op_t   alu_op_d;
    reg_addr_t rd_d;
    logic      hold;

    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt,
                                        input logic reg_form);
        case (f3)
            F3_ADD:  alu_sel = (alt && reg_form) ? ALU_SUB : ALU_ADD;
            F3_SLL:  alu_sel = ALU_SLL;
            F3_SLT:  alu_sel = ALU_SLT;
            F3_SLTU: alu_sel = ALU_SLTU;
            F3_XOR:  alu_sel = ALU_XOR;
            F3_SR:   alu_sel = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   alu_sel = ALU_OR;
            F3_AND:  alu_sel = ALU_AND;
            default: alu_sel = ALU_ADD;
        endcase
    endfunction

    // Newest copy of a register
    function automatic word_t fwd(input reg_addr_t rs, input word_t rf_val);
        if ((rs != '0) && (rs == ex_rd) && !ex_is_load)
            fwd = ex_result;
        else if (wb_en && (rs == wb_rd))
            fwd = wb_data;
        else
            fwd = rf_val;
    endfunction

    assign rs1 = instr_q[19:15];
    assign rs2 = instr_q[24:20];

    reg_file rf0 (
        .CLK   (CLK),
        .rst_n (rst_n),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd1   (rf_a),
        .rd2   (rf_b),
        .we    (wb_en),
        .wa    (wb_rd),
        .wd    (wb_data)
    );

    always_comb
    begin
        alu_op_d = ALU_ADD;
        imm      = {{20{instr_q[31]}}, instr_q[31:20]};
        b_is_imm = 1'b1;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        load_d   = 1'b0;
        store_d  = 1'b0;
        rd_d     = '0;
        case (instr_q[6:0])
            OPC_OP:
            begin
                alu_op_d = alu_sel(instr_q[14:12], instr_q[30], 1'b1);
                b_is_imm = 1'b0;
                use_rs1  = 1'b1;
                use_rs2  = 1'b1;
                rd_d     = instr_q[11:7];
            end
            OPC_OP_IMM:
            begin
                alu_op_d = alu_sel(instr_q[14:12], instr_q[30], 1'b0);
                use_rs1  = 1'b1;
                rd_d     = instr_q[11:7];
            end
            OPC_LUI:
            begin
                alu_op_d = ALU_PASS_B;
                imm      = {instr_q[31:12], 12'd0};
                rd_d     = instr_q[11:7];
            end
            OPC_LOAD:
            begin
                use_rs1 = 1'b1;
                load_d  = 1'b1;
                rd_d    = instr_q[11:7];
            end
            OPC_STORE:
            begin
                imm     = {{20{instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                store_d = 1'b1;
            end
            default:
            begin
                // Anything else runs as a no-op
                rd_d = '0;
            end
        endcase
    end

    always_comb
    begin
        fwd_a = fwd(rs1, rf_a);
        fwd_b = fwd(rs2, rf_b);
    end

    // Load result not ready until the result register
    assign hold = ex_is_load && (ex_rd != '0) &&
                  ((use_rs1 && (rs1 == ex_rd)) || (use_rs2 && (rs2 == ex_rd)));
    assign take = !hold;

    //////////////////////////////
    // Decode and execute registers
    //////////////////////////////

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            instr_q <= NOP_WORD;
        end
        else if (advance && !hold)
        begin
            instr_q <= ins_valid ? ins : NOP_WORD;
        end
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            op_a      <= '0;
            op_b      <= '0;
            store_val <= '0;
            alu_op    <= ALU_ADD;
            mem_size  <= SIZE_B;
            is_load   <= 1'b0;
            is_store  <= 1'b0;
            rd        <= '0;
        end
        else if (advance)
        begin
            if (hold)
            begin
                op_a      <= '0;
                op_b      <= '0;
                store_val <= '0;
                alu_op    <= ALU_ADD;
                mem_size  <= SIZE_B;
                is_load   <= 1'b0;
                is_store  <= 1'b0;
                rd        <= '0;
            end
            else
            begin
                op_a      <= fwd_a;
                op_b      <= b_is_imm ? imm : fwd_b;
                store_val <= fwd_b;
                alu_op    <= alu_op_d;
                mem_size  <= instr_q[14:12];
                is_load   <= load_d;
                is_store  <= store_d;
                rd        <= rd_d;
            end
        end
    end

    // The bubble lets the load reach the result register
    property p_hold_once;
        @(posedge CLK) disable iff (!rst_n)
        (hold && advance) |=> !hold;
    endproperty
    a_hold_once: assert property (p_hold_once);

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                advance,
    input  core_pkg::word_t     op_a,
    input  core_pkg::word_t     op_b,
    input  core_pkg::word_t     store_val,
    input  core_pkg::alu_op_t   alu_op,
    input  core_pkg::mem_size_t mem_size,
    input  logic                is_load,
    input  logic                is_store,
    input  core_pkg::reg_addr_t rd,
    output core_pkg::word_t     ex_result,
    output core_pkg::reg_addr_t ex_rd,
    output logic                ex_is_load,
    output logic                mem_read,
    output logic                mem_write,
    output core_pkg::word_t     mem_addr,
    output core_pkg::byte_en_t  mem_byte_en,
    output core_pkg::word_t     mem_wdata,
    output core_pkg::word_t     res_value,
    output logic [1:0]          res_offset,
    output core_pkg::mem_size_t res_size,
    output logic                res_load,
    output logic                res_en,
    output core_pkg::reg_addr_t res_rd
);
    import core_pkg::*;

    word_t      alu_res;
    logic [1:0] offset;
    logic [4:0] shamt;

    assign shamt = op_b[4:0];

    always_comb
    begin
        case (alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_SLT:    alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'd0, op_a < op_b};
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    //////////////////////////////
    // Memory request
    //////////////////////////////

    assign offset    = alu_res[1:0];
    assign mem_read  = is_load;
    assign mem_write = is_store;
    assign mem_addr  = {alu_res[31:2], 2'b00};

    // Word stores keep their lanes
    assign mem_wdata = (mem_size == SIZE_W) ? store_val : (store_val << {offset, 3'b000});

    always_comb
    begin
        mem_byte_en = 4'b0000;
        if (is_store)
        begin
            case (mem_size)
                SIZE_B:  mem_byte_en = 4'b0001 << offset;
                SIZE_H:  mem_byte_en = (offset == 2'd3) ? 4'b0000 : (4'b0011 << offset);
                SIZE_W:  mem_byte_en = 4'b1111;
                default: mem_byte_en = 4'b0000;
            endcase
        end
    end

    // Forwarding view of this stage
    assign ex_result  = alu_res;
    assign ex_rd      = rd;
    assign ex_is_load = is_load;

    // Write-back fields for the result register
    assign res_value  = alu_res;
    assign res_offset = offset;
    assign res_size   = mem_size;
    assign res_load   = is_load;
    assign res_en     = (rd != '0);
    assign res_rd     = rd;

    a_one_request: assert property (
        @(posedge CLK) disable iff (!rst_n) !(mem_read && mem_write));

    // Frozen pipeline keeps the request steady
    property p_req_stable;
        @(posedge CLK) disable iff (!rst_n)
        ((mem_read || mem_write) && !advance) |=>
            ($stable(mem_read) && $stable(mem_write) && $stable(mem_addr) &&
             $stable(mem_byte_en) && $stable(mem_wdata));
    endproperty
    a_req_stable: assert property (p_req_stable);

endmodule

//--- hw/int_pipeline.sv
`timescale 1ns/1ps

module int_pipeline (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               ins_valid,
    input  core_pkg::word_t    ins,
    output logic               ins_ready,
    output logic               mem_read,
    output logic               mem_write,
    output core_pkg::word_t    mem_addr,
    output core_pkg::byte_en_t mem_byte_en,
    output core_pkg::word_t    mem_wdata,
    input  core_pkg::word_t    mem_rdata,
    input  logic               mem_ready
);
    import core_pkg::*;

    logic       advance;
    logic       take;
    reg_addr_t  ex_rd;
    word_t      ex_result;
    logic       ex_is_load;
    logic       wb_en;
    reg_addr_t  wb_rd;
    word_t      wb_data;
    word_t      op_a;
    word_t      op_b;
    word_t      store_val;
    alu_op_t    alu_op;
    mem_size_t  mem_size;
    logic       is_load;
    logic       is_store;
    reg_addr_t  rd;
    word_t      res_value;
    logic [1:0] res_offset;
    mem_size_t  res_size;
    logic       res_load;
    logic       res_en;
    reg_addr_t  res_rd;

    // Freeze everything while memory holds a request
    assign advance   = !(mem_read || mem_write) || mem_ready;
    assign ins_ready = advance && take;

    decode_stage dec0 (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .advance    (advance),
        .ins_valid  (ins_valid),
        .ins        (ins),
        .take       (take),
        .ex_rd      (ex_rd),
        .ex_result  (ex_result),
        .ex_is_load (ex_is_load),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .op_a       (op_a),
        .op_b       (op_b),
        .store_val  (store_val),
        .alu_op     (alu_op),
        .mem_size   (mem_size),
        .is_load    (is_load),
        .is_store   (is_store),
        .rd         (rd)
    );

    execute_stage ex0 (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .advance     (advance),
        .op_a        (op_a),
        .op_b        (op_b),
        .store_val   (store_val),
        .alu_op      (alu_op),
        .mem_size    (mem_size),
        .is_load     (is_load),
        .is_store    (is_store),
        .rd          (rd),
        .ex_result   (ex_result),
        .ex_rd       (ex_rd),
        .ex_is_load  (ex_is_load),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_byte_en (mem_byte_en),
        .mem_wdata   (mem_wdata),
        .res_value   (res_value),
        .res_offset  (res_offset),
        .res_size    (res_size),
        .res_load    (res_load),
        .res_en      (res_en),
        .res_rd      (res_rd)
    );

    result_stage res0 (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .advance    (advance),
        .mem_rdata  (mem_rdata),
        .res_value  (res_value),
        .res_offset (res_offset),
        .res_size   (res_size),
        .res_load   (res_load),
        .res_en     (res_en),
        .res_rd     (res_rd),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

//--- hw/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic               CLK,
    input  logic               rst_n,
    input  core_pkg::reg_addr_t rs1,
    input  core_pkg::reg_addr_t rs2,
    output core_pkg::word_t    rd1,
    output core_pkg::word_t    rd2,
    input  logic               we,
    input  core_pkg::reg_addr_t wa,
    input  core_pkg::word_t    wd
);
    import core_pkg::*;

    // x1 to x31, x0 has no storage
    word_t regs [1:31];

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 1; i < 32; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (we && (wa != '0))
        begin
            regs[wa] <= wd;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- hw/result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                advance,
    input  core_pkg::word_t     mem_rdata,
    input  core_pkg::word_t     res_value,
    input  logic [1:0]          res_offset,
    input  core_pkg::mem_size_t res_size,
    input  logic                res_load,
    input  logic                res_en,
    input  core_pkg::reg_addr_t res_rd,
    output logic                wb_en,
    output core_pkg::reg_addr_t wb_rd,
    output core_pkg::word_t     wb_data
);
    import core_pkg::*;

    word_t lane;
    word_t load_val;

    // Addressed byte lane moved down to bit 0
    assign lane = mem_rdata >> {res_offset, 3'b000};

    always_comb
    begin
        case (res_size)
            SIZE_B:  load_val = {{24{lane[7]}}, lane[7:0]};
            SIZE_BU: load_val = {24'd0, lane[7:0]};
            SIZE_H:  load_val = (res_offset == 2'd3) ? '0 : {{16{lane[15]}}, lane[15:0]};
            SIZE_HU: load_val = (res_offset == 2'd3) ? '0 : {16'd0, lane[15:0]};
            SIZE_W:  load_val = mem_rdata;
            default: load_val = mem_rdata;
        endcase
    end

    always_ff @(posedge CLK or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wb_en   <= 1'b0;
            wb_rd   <= '0;
            wb_data <= '0;
        end
        else if (advance)
        begin
            wb_en   <= res_en;
            wb_rd   <= res_rd;
            wb_data <= res_load ? load_val : res_value;
        end
    end

endmodule

//--- sim.f
hw/core_pkg.sv
hw/reg_file.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/int_pipeline.sv
testbench/tb_int_pipeline.sv

//--- testbench/tb_int_pipeline.sv
`timescale 1ns/1ps

module tb_int_pipeline;
    import core_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic       CLK;
    logic       rst_n;
    logic       ins_valid;
    word_t      ins;
    logic       ins_ready;
    logic       mem_read;
    logic       mem_write;
    word_t      mem_addr;
    byte_en_t   mem_byte_en;
    word_t      mem_wdata;
    word_t      mem_rdata;
    logic       mem_ready;

    word_t      mem [0:63];
    word_t      shadow [0:63];
    integer     seed;
    int         cycles;
    int         checks;
    int         errors;
    int         wait_cnt;
    bit         rand_on;
    bit         prev_wait;
    word_t      prev_addr;
    word_t      prev_wdata;
    byte_en_t   prev_be;
    logic       prev_rd;
    logic       prev_wr;
    byte_en_t   last_be;
    word_t      last_wd;
    int         stall_seen;

    int_pipeline dut0 (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .ins_valid   (ins_valid),
        .ins         (ins),
        .ins_ready   (ins_ready),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_byte_en (mem_byte_en),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready)
    );

    always #4 CLK = ~CLK;

    always @(posedge CLK)
    begin
        cycles++;
    end

    initial
    begin
        wait (cycles >= MAX_CYCLES);
        $display("Timeout after %0d cycles, the pipeline stopped making progress", cycles);
        $display("Result: FAILED");
        $finish;
    end

    //////////////////////////////
    // Memory model
    //////////////////////////////

    always @(negedge CLK)
    begin
        mem_ready = 1'b0;
        if (mem_read && mem_write)
        begin
            errors++;
            $display("mem_read and mem_write were high together");
        end
        if (prev_wait && ((mem_addr != prev_addr) || (mem_byte_en != prev_be) ||
                          (mem_wdata != prev_wdata) || (mem_read != prev_rd) ||
                          (mem_write != prev_wr)))
        begin
            errors++;
            $display("Memory request changed while waiting for mem_ready");
        end
        prev_wait = 1'b0;
        if (rst_n && (mem_read || mem_write))
        begin
            if (wait_cnt < 0)
                wait_cnt = rand_on ? ({$random(seed)} % 3) : 0;
            if (wait_cnt == 0)
            begin
                mem_ready = 1'b1;
                wait_cnt  = -1;
                mem_rdata = mem[mem_addr[7:2]];
                if (mem_write)
                begin
                    for (int k = 0; k < 4; k++)
                    begin
                        if (mem_byte_en[k])
                            mem[mem_addr[7:2]][8*k +: 8] = mem_wdata[8*k +: 8];
                    end
                    last_be = mem_byte_en;
                    last_wd = mem_wdata;
                end
            end
            else
            begin
                wait_cnt--;
                prev_wait  = 1'b1;
                prev_addr  = mem_addr;
                prev_be    = mem_byte_en;
                prev_wdata = mem_wdata;
                prev_rd    = mem_read;
                prev_wr    = mem_write;
                #1;
                if (ins_ready)
                begin
                    errors++;
                    $display("ins_ready was high while a memory request waited");
                end
            end
        end
    end

    // Instruction encoders
    function automatic word_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3,
                                    input reg_addr_t rd);
        enc_r = {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input logic [2:0] f3, input reg_addr_t rd,
                                    input logic [6:0] opc);
        enc_i = {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1, input logic [2:0] f3);
        enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_lui(input reg_addr_t rd, input logic [19:0] imm);
        enc_lui = {imm, rd, OPC_LUI};
    endfunction

    // Offer one instruction until the pipeline takes it
    task automatic send(input word_t w);
        @(negedge CLK);
        ins       = w;
        ins_valid = 1'b1;
        #2;
        while (!ins_ready)
        begin
            stall_seen++;
            @(negedge CLK);
            #2;
        end
    endtask

    task automatic drain();
        repeat (4) send(NOP_WORD);
    endtask

    task automatic check_value(input string name, input word_t exp, input word_t act);
        checks++;
        if (exp !== act)
        begin
            errors++;
            $display("Error %s: expected %08h, actual %08h", name, exp, act);
        end
    endtask

    task automatic report(input string name, input int errs_before);
        if (errors == errs_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errs_before);
    endtask

    task automatic test_alu();
        int    e0;
        word_t exp [0:10];
        int    regs [0:10];
        e0 = errors;
        send(enc_i(12'hFFB, 0, F3_ADD, 1, OPC_OP_IMM));
        send(enc_lui(2, 20'h12345));
        send(enc_i(12'h678, 2, F3_ADD, 2, OPC_OP_IMM));
        send(enc_i(12'd4, 0, F3_ADD, 9, OPC_OP_IMM));
        send(enc_r(7'h00, 2, 1, F3_ADD, 3));
        send(enc_r(7'h20, 1, 2, F3_ADD, 4));
        send(enc_r(7'h00, 2, 1, F3_AND, 5));
        send(enc_r(7'h00, 2, 1, F3_OR, 6));
        send(enc_r(7'h00, 2, 1, F3_XOR, 7));
        send(enc_r(7'h00, 9, 2, F3_SLL, 8));
        send(enc_r(7'h00, 9, 1, F3_SR, 10));
        send(enc_r(7'h20, 9, 1, F3_SR, 11));
        send(enc_r(7'h00, 2, 1, F3_SLT, 12));
        send(enc_r(7'h00, 2, 1, F3_SLTU, 13));
        send(enc_i(12'h401, 1, F3_SR, 14, OPC_OP_IMM));
        // x1 is -5, x2 is 32'h1234_5678
        exp[0]  = 32'h1234_5673;
        exp[1]  = 32'h1234_567D;
        exp[2]  = 32'h1234_5678;
        exp[3]  = 32'hFFFF_FFFB;
        exp[4]  = 32'hEDCB_A983;
        exp[5]  = 32'h2345_6780;
        exp[6]  = 32'h0FFF_FFFF;
        exp[7]  = 32'hFFFF_FFFF;
        exp[8]  = 32'd1;
        exp[9]  = 32'd0;
        exp[10] = 32'hFFFF_FFFD;
        regs = '{3, 4, 5, 6, 7, 8, 10, 11, 12, 13, 14};
        for (int k = 0; k < 11; k++)
            send(enc_s(12'(4 * k), 5'(regs[k]), 0, SIZE_W));
        drain();
        for (int k = 0; k < 11; k++)
            check_value($sformatf("alu x%0d", regs[k]), exp[k], mem[k]);
        report("alu", e0);
    endtask

    task automatic test_store();
        int        e0;
        word_t     val;
        word_t     mask;
        byte_en_t  be;
        mem_size_t sizes [0:2];
        e0    = errors;
        val   = 32'hA1B2_C3D4;
        sizes = '{SIZE_B, SIZE_H, SIZE_W};
        send(enc_lui(1, 20'hA1B2C));
        send(enc_i(12'h3D4, 1, F3_ADD, 1, OPC_OP_IMM));
        for (int s = 0; s < 3; s++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                last_be = 'x;
                last_wd = 'x;
                send(enc_s(12'(12'h040 + off), 1, 0, sizes[s]));
                drain();
                if (s == 0)
                    be = 4'b0001 << off;
                else if (s == 1)
                    be = (off == 3) ? 4'b0000 : (4'b0011 << off);
                else
                    be = 4'b1111;
                mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
                check_value($sformatf("store size %0d off %0d enables", s, off),
                            32'(be), 32'(last_be));
                if (be != 4'b0000)
                    check_value($sformatf("store size %0d off %0d data", s, off),
                                (val << (8 * (s == 2 ? 0 : off))) & mask, last_wd & mask);
            end
        end
        report("store", e0);
    endtask

    task automatic test_load();
        int        e0;
        word_t     w;
        word_t     lane;
        word_t     exp;
        mem_size_t sizes [0:4];
        e0    = errors;
        w     = 32'h81F2_7364;
        sizes = '{SIZE_B, SIZE_BU, SIZE_H, SIZE_HU, SIZE_W};
        mem[32] = w;
        for (int s = 0; s < 5; s++)
        begin
            for (int off = 0; off < 4; off++)
            begin
                send(enc_i(12'(12'h080 + off), 0, sizes[s], 5, OPC_LOAD));
                send(enc_s(12'h084, 5, 0, SIZE_W));
                drain();
                lane = w >> (8 * off);
                case (sizes[s])
                    SIZE_B:  exp = {{24{lane[7]}}, lane[7:0]};
                    SIZE_BU: exp = {24'd0, lane[7:0]};
                    SIZE_H:  exp = (off == 3) ? 32'd0 : {{16{lane[15]}}, lane[15:0]};
                    SIZE_HU: exp = (off == 3) ? 32'd0 : {16'd0, lane[15:0]};
                    default: exp = w;
                endcase
                check_value($sformatf("load size %0d off %0d", sizes[s], off), exp, mem[33]);
            end
        end
        report("load", e0);
    endtask

    task automatic test_load_use();
        int e0;
        e0 = errors;
        mem[34] = 32'd100;
        send(enc_i(12'd23, 0, F3_ADD, 6, OPC_OP_IMM));
        stall_seen = 0;
        send(enc_i(12'h088, 0, SIZE_W, 7, OPC_LOAD));
        send(enc_r(7'h00, 6, 7, F3_ADD, 8));
        send(enc_s(12'h08C, 8, 0, SIZE_W));
        if (stall_seen == 0)
        begin
            errors++;
            $display("ins_ready never went low between the load and its use");
        end
        drain();
        check_value("load_use sum", 32'd123, mem[35]);
        report("load_use", e0);
    endtask

    // Lane merge of a store into the expected memory
    task automatic store_shadow(input int idx, input int off, input int nbytes,
                                input word_t val);
        for (int k = 0; k < nbytes; k++)
            shadow[idx][8 * (off + k) +: 8] = val[8 * k +: 8];
    endtask

    task automatic test_random_mem();
        int          e0;
        int          kind;
        int          wa;
        int          wb;
        int          off;
        logic [11:0] imm;
        e0      = errors;
        rand_on = 1'b1;
        for (int i = 0; i < 64; i++)
            shadow[i] = mem[i];
        for (int n = 0; n < 16; n++)
        begin
            kind = {$random(seed)} % 4;
            wa   = 48 + ({$random(seed)} % 8);
            wb   = 48 + ({$random(seed)} % 8);
            imm  = 12'($random(seed));
            off  = {$random(seed)} % 4;
            send(enc_i(imm, 0, F3_ADD, 10, OPC_OP_IMM));
            if (kind == 0)
            begin
                send(enc_s(12'(4 * wa + off), 10, 0, SIZE_B));
                store_shadow(wa, off, 1, {{20{imm[11]}}, imm});
            end
            else if (kind == 1)
            begin
                send(enc_s(12'(4 * wa + 2 * (off % 2)), 10, 0, SIZE_H));
                store_shadow(wa, 2 * (off % 2), 2, {{20{imm[11]}}, imm});
            end
            else if (kind == 2)
            begin
                send(enc_s(12'(4 * wa), 10, 0, SIZE_W));
                store_shadow(wa, 0, 4, {{20{imm[11]}}, imm});
            end
            else
            begin
                send(enc_i(12'(4 * wa), 0, SIZE_W, 11, OPC_LOAD));
                send(enc_s(12'(4 * wb), 11, 0, SIZE_W));
                shadow[wb] = shadow[wa];
            end
        end
        drain();
        rand_on = 1'b0;
        for (int i = 48; i < 56; i++)
            check_value($sformatf("random_mem word %0d", i), shadow[i], mem[i]);
        report("random_mem", e0);
    endtask

    task automatic test_x0();
        int e0;
        e0 = errors;
        send(enc_i(12'd77, 0, F3_ADD, 0, OPC_OP_IMM));
        send(enc_s(12'h0F0, 0, 0, SIZE_W));
        drain();
        check_value("x0 store", 32'd0, mem[60]);
        report("x0", e0);
    endtask

    initial
    begin
        CLK       = 1'b0;
        rst_n     = 1'b0;
        ins_valid = 1'b0;
        ins       = NOP_WORD;
        mem_rdata = '0;
        mem_ready = 1'b0;
        seed      = 2100;
        cycles    = 0;
        checks    = 0;
        errors    = 0;
        wait_cnt  = -1;
        rand_on   = 1'b0;
        prev_wait = 1'b0;
        last_be   = '0;
        last_wd   = '0;
        stall_seen = 0;
        for (int i = 0; i < 64; i++)
            mem[i] = 32'h5A00_0000 ^ (i * 32'h0103_0507);
        repeat (3) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        test_alu();
        test_store();
        test_load();
        test_load_use();
        test_random_mem();
        test_x0();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
